// ==== src.f ====
+incdir+.
sdram_pkg.sv
sdram_request_fsm.sv
sdram_csr.sv
sdram_bridge_top.sv
tb_avl_memory.sv
tb_checker.sv
tb_sdram_bridge.sv

// ==== Bender.yml ====
package:
  name: sdram_bridge

export_include_dirs:
  - .

sources:
  # RTL
  - sdram_pkg.sv
  - sdram_request_fsm.sv
  - sdram_csr.sv
  - sdram_bridge_top.sv

  # testbench
  - target: test
    files:
      - tb_avl_memory.sv
      - tb_checker.sv
      - tb_sdram_bridge.sv

// ==== tb_sdram_bridge.sv ====
// SDRAM bridge testbench
`timescale 1ns/10ps
`include "sdram_config.svh"

module tb_sdram_bridge
	import sdram_pkg::*;
();

	localparam int INIT_DELAY = 30;
	localparam int ROW_SLACK = 20;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_CSR_WR, OP_CSR_RD} op_e;

	typedef struct {
		logic [127:0] name;
		op_e op;
		logic [31:0] addr; // register index for register rows.
		logic [31:0] data;
		logic stall;
		logic gated; // raised while disabled.
		logic expect_error;
	} row_t;

	logic clock;
	logic reset;
	logic request;
	mem_req_t req;
	logic [`SDRAM_DATA_W-1:0] rdata;
	logic ready;
	logic error;
	logic csr_write;
	csr_index_e csr_index;
	logic [`SDRAM_DATA_W-1:0] csr_wdata;
	logic [`SDRAM_DATA_W-1:0] csr_rdata;
	avl_cmd_t avl_cmd;
	logic avl_ready;
	logic avl_rdata_valid;
	logic [`SDRAM_DATA_W-1:0] avl_rdata;
	logic init_done;
	logic stall;
	logic check_csr;
	logic finish_run;
	logic expect_error;
	logic [127:0] test_name;
	logic table_ready;
	row_t rows [$];
	int error_count;
	int cycle_count;
	int max_cycles;

	sdram_bridge_top dut_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_req(req),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_error(error),
		.i_csr_write(csr_write),
		.i_csr_index(csr_index),
		.i_csr_wdata(csr_wdata),
		.o_csr_rdata(csr_rdata),
		.o_avl_cmd(avl_cmd),
		.i_avl_ready(avl_ready),
		.i_avl_rdata_valid(avl_rdata_valid),
		.i_avl_rdata(avl_rdata),
		.i_init_done(init_done)
	);

	tb_avl_memory #(.INIT_DELAY(INIT_DELAY)) memory_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_cmd(avl_cmd),
		.i_stall(stall),
		.o_ready(avl_ready),
		.o_rdata_valid(avl_rdata_valid),
		.o_rdata(avl_rdata),
		.o_init_done(init_done)
	);

	tb_checker checker_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_test_name(test_name),
		.i_expect_error(expect_error),
		.i_check_csr(check_csr),
		.i_finish(finish_run),
		.i_req(req),
		.i_rdata(rdata),
		.i_ready(ready),
		.i_error(error),
		.i_csr_write(csr_write),
		.i_csr_index(csr_index),
		.i_csr_wdata(csr_wdata),
		.i_csr_rdata(csr_rdata),
		.i_avl_cmd(avl_cmd),
		.i_init_done(init_done),
		.o_error_count(error_count)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// ------------------------------
	// watchdog
	// ------------------------------

	initial begin
		cycle_count = 0;
		wait (table_ready === 1'b1);
		while (cycle_count < max_cycles) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("run stopped after %0d cycles, a transfer never completed", cycle_count);
		$display("Verification failed");
		$finish;
	end

	task automatic add_row(input logic [127:0] name, input op_e op, input logic [31:0] addr,
			input logic [31:0] data, input logic stall_row, input logic gated, input logic fails);
		row_t r;
		r = '{name, op, addr, data, stall_row, gated, fails};
		rows.push_back(r);
	endtask

	task automatic write_csr(input csr_index_e index, input logic [31:0] value);
		@(negedge clock);
		csr_write = 1'b1;
		csr_index = index;
		csr_wdata = value;
		@(negedge clock);
		csr_write = 1'b0;
	endtask

	task automatic run_row(input row_t r);
		test_name = r.name;
		expect_error = r.expect_error;
		case (r.op)
			OP_CSR_WR: write_csr(csr_index_e'(r.addr[2:0]), r.data);
			OP_CSR_RD: begin
				@(negedge clock);
				csr_index = csr_index_e'(r.addr[2:0]);
				check_csr = 1'b1;
				@(negedge clock);
				check_csr = 1'b0;
			end
			default: begin
				@(negedge clock);
				req.rw = (r.op == OP_WRITE);
				req.addr = r.addr;
				req.wdata = r.data;
				stall = r.stall;
				request = 1'b1;
				if (r.gated) begin
					repeat (ROW_SLACK) @(posedge clock);
					write_csr(CSR_CTRL, 32'd1);
				end
				do @(posedge clock); while (!(ready || error));
				@(negedge clock);
				request = 1'b0;
				stall = 1'b0;
			end
		endcase
	endtask

	initial begin
		void'($urandom(32'h630b04f9));
		table_ready = 1'b0;
		reset = 1'b1;
		request = 1'b0;
		req = '0;
		csr_write = 1'b0;
		csr_index = CSR_CTRL;
		csr_wdata = '0;
		stall = 1'b0;
		check_csr = 1'b0;
		finish_run = 1'b0;
		expect_error = 1'b0;
		test_name = '0;

		// name, op, address or index, data, stall, gated, error expected
		add_row("early_write", OP_WRITE, 32'h0000_0100, 32'h1111_aaaa, 0, 0, 0);
		add_row("write_a", OP_WRITE, 32'h0000_0104, 32'h2222_bbbb, 0, 0, 0);
		add_row("write_b", OP_WRITE, 32'h1fff_fffc, 32'h3333_cccc, 0, 0, 0);
		add_row("read_early", OP_READ, 32'h0000_0100, 32'h0, 0, 0, 0);
		add_row("read_a", OP_READ, 32'h0000_0104, 32'h0, 0, 0, 0);
		add_row("read_b", OP_READ, 32'h1fff_fffc, 32'h0, 0, 0, 0);
		add_row("overwrite_a", OP_WRITE, 32'h0000_0104, 32'h5555_eeee, 0, 0, 0);
		add_row("reread_a", OP_READ, 32'h0000_0104, 32'h0, 0, 0, 0);
		add_row("disable", OP_CSR_WR, 32'(CSR_CTRL), 32'h0, 0, 0, 0);
		add_row("gated_write", OP_WRITE, 32'h0100_0200, 32'h6666_0001, 0, 1, 0);
		add_row("gated_read", OP_READ, 32'h0100_0200, 32'h0, 0, 0, 0);
		add_row("short_limit", OP_CSR_WR, 32'(CSR_TIMEOUT), 32'd24, 0, 0, 0);
		add_row("stall_write", OP_WRITE, 32'h0000_0104, 32'hdead_beef, 1, 0, 1);
		add_row("stall_read", OP_READ, 32'h0000_0100, 32'h0, 1, 0, 1);
		add_row("after_stall", OP_READ, 32'h0000_0104, 32'h0, 0, 0, 0);
		add_row("rd_reads", OP_CSR_RD, 32'(CSR_READS), 32'h0, 0, 0, 0);
		add_row("rd_writes", OP_CSR_RD, 32'(CSR_WRITES), 32'h0, 0, 0, 0);
		add_row("rd_timeouts", OP_CSR_RD, 32'(CSR_TIMEOUTS), 32'h0, 0, 0, 0);
		add_row("rd_limit", OP_CSR_RD, 32'(CSR_TIMEOUT), 32'h0, 0, 0, 0);
		add_row("clr_reads", OP_CSR_WR, 32'(CSR_READS), 32'h0, 0, 0, 0);
		add_row("rd_reads_clr", OP_CSR_RD, 32'(CSR_READS), 32'h0, 0, 0, 0);
		add_row("rd_ctrl", OP_CSR_RD, 32'(CSR_CTRL), 32'h0, 0, 0, 0);

		max_cycles = rows.size() * (`SDRAM_TIMEOUT_DEFAULT + ROW_SLACK) + INIT_DELAY + 8;
		table_ready = 1'b1;

		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		foreach (rows[i]) begin
			run_row(rows[i]);
		end

		@(negedge clock);
		finish_run = 1'b1;
		#1;
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== tb_checker.sv ====
// SDRAM bridge response checker
`timescale 1ns/10ps
`include "sdram_config.svh"

module tb_checker
	import sdram_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	input logic [127:0] i_test_name,
	input logic i_expect_error,
	input logic i_check_csr,
	input logic i_finish,
	input mem_req_t i_req,
	input logic [`SDRAM_DATA_W-1:0] i_rdata,
	input logic i_ready,
	input logic i_error,
	input logic i_csr_write,
	input csr_index_e i_csr_index,
	input logic [`SDRAM_DATA_W-1:0] i_csr_wdata,
	input logic [`SDRAM_DATA_W-1:0] i_csr_rdata,
	input avl_cmd_t i_avl_cmd,
	input logic i_init_done,
	output int o_error_count
);

	logic [`SDRAM_DATA_W-1:0] shadow [logic [`SDRAM_AVL_ADDR_W-1:0]];
	logic enable;
	logic [15:0] limit;
	int count [3]; // reads, writes, timeouts.
	int value_errors = 0;
	int other_errors = 0;

	assign o_error_count = value_errors + other_errors;

	task automatic value_error(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("** Error: %0s %0s expected %h actual %h", i_test_name, what, expected, actual);
		value_errors++;
	endtask

	task automatic other_error(input string what);
		$display("Failure in %0s: %0s", i_test_name, what);
		other_errors++;
	endtask

	function automatic logic [31:0] csr_model(input csr_index_e index);
		case (index)
			CSR_CTRL: return {31'd0, enable};
			CSR_TIMEOUT: return {16'd0, limit};
			CSR_READS, CSR_WRITES, CSR_TIMEOUTS: return 32'(count[int'(index) - 2]);
			default: return '0;
		endcase
	endfunction

	// ------------------------------
	// per cycle checks
	// ------------------------------

	always @(posedge i_clock) begin
		logic [`SDRAM_ADDR_W-1:0] word_index;
		logic [`SDRAM_AVL_ADDR_W-1:0] word;
		logic cmd_on;
		word_index = i_req.addr >> 2; // byte address to word number.
		word = word_index[`SDRAM_AVL_ADDR_W-1:0];
		cmd_on = i_avl_cmd.read_req || i_avl_cmd.write_req;
		if (i_reset) begin
			shadow.delete();
			enable = 1'b1;
			limit = `SDRAM_TIMEOUT_DEFAULT;
			count = '{0, 0, 0};
		end else begin
			if (cmd_on && !i_init_done) begin
				other_error("command issued before controller init");
			end
			if (!enable && (cmd_on || i_ready || i_error)) begin
				other_error("bridge active while disabled");
			end
			if (cmd_on) begin
				if ({i_avl_cmd.read_req, i_avl_cmd.write_req} != {!i_req.rw, i_req.rw}) begin
					value_error("command type", 32'({!i_req.rw, i_req.rw}),
						32'({i_avl_cmd.read_req, i_avl_cmd.write_req}));
				end
				if (!i_avl_cmd.burstbegin) begin
					other_error("burstbegin low while a request is asserted");
				end
				if (i_avl_cmd.addr !== word) begin
					value_error("word address", 32'(word), 32'(i_avl_cmd.addr));
				end
				if (i_req.rw && (i_avl_cmd.wdata !== i_req.wdata)) begin
					value_error("command write data", i_req.wdata, i_avl_cmd.wdata);
				end
			end else if (i_avl_cmd.burstbegin) begin
				other_error("burstbegin high with no request asserted");
			end
			if (i_ready && i_error) begin
				other_error("ready and error pulsed together");
			end
			if ((i_ready || i_error) && (i_error != i_expect_error)) begin
				value_error("error pulse", 32'(i_expect_error), 32'(i_error));
			end
			if (i_ready && i_req.rw) begin
				shadow[word] = i_req.wdata;
				count[1]++;
			end else if (i_ready) begin
				if (!shadow.exists(word)) begin
					other_error("read of an address never written");
				end else if (i_rdata !== shadow[word]) begin
					value_error("read data", shadow[word], i_rdata);
				end
				count[0]++;
			end
			if (i_error) begin
				count[2]++;
			end
			if (i_check_csr && (i_csr_rdata !== csr_model(i_csr_index))) begin
				value_error("register", csr_model(i_csr_index), i_csr_rdata);
			end
			if (i_csr_write) begin
				case (i_csr_index)
					CSR_CTRL: enable = i_csr_wdata[0];
					CSR_TIMEOUT: limit = i_csr_wdata[15:0];
					CSR_READS, CSR_WRITES, CSR_TIMEOUTS: count[int'(i_csr_index) - 2] = 0;
					default: ;
				endcase
			end
		end
	end

	always @(posedge i_finish) begin
		$display("checks done: %0d value errors, %0d other errors, %0d reads, %0d writes, %0d timeouts",
			value_errors, other_errors, count[0], count[1], count[2]);
	end

endmodule

// ==== tb_avl_memory.sv ====
// Behavioral SDRAM controller model
`timescale 1ns/10ps
`include "sdram_config.svh"

module tb_avl_memory
	import sdram_pkg::*;
#(
	parameter int INIT_DELAY = 30
) (
	input logic i_clock,
	input logic i_reset,
	input avl_cmd_t i_cmd,
	input logic i_stall, // withhold acceptance.
	output logic o_ready,
	output logic o_rdata_valid,
	output logic [`SDRAM_DATA_W-1:0] o_rdata,
	output logic o_init_done
);

	logic [`SDRAM_DATA_W-1:0] mem [logic [`SDRAM_AVL_ADDR_W-1:0]];
	logic [`SDRAM_DATA_W-1:0] data_q [$];
	int due_q [$]; // cycle each pending word is returned.
	int cycle;
	int due;
	int init_count;
	logic ready_q;

	assign o_ready = ready_q && !i_stall;

	// unwritten words read back a pattern of their full address
	function automatic logic [`SDRAM_DATA_W-1:0] fill_word(
			input logic [`SDRAM_AVL_ADDR_W-1:0] addr);
		return {addr, 5'h15} ^ 32'h3c96_0f5a;
	endfunction

	initial begin
		ready_q = 1'b0;
		o_rdata_valid = 1'b0;
		o_rdata = '0;
		o_init_done = 1'b0;
	end

	always @(posedge i_clock) begin
		if (i_reset) begin
			ready_q <= 1'b0;
			o_rdata_valid <= 1'b0;
			o_rdata <= '0;
			o_init_done <= 1'b0;
			cycle = 0;
			init_count = 0;
			data_q.delete();
			due_q.delete();
		end else begin
			cycle++;
			if (init_count < INIT_DELAY) begin
				init_count++;
			end else begin
				o_init_done <= 1'b1;
			end
			if (o_ready && i_cmd.write_req) begin
				mem[i_cmd.addr] = i_cmd.wdata;
			end
			if (o_ready && i_cmd.read_req) begin
				due = cycle + $urandom_range(6, 1); // random latency.
				if ((due_q.size() > 0) && (due <= due_q[$])) begin
					due = due_q[$] + 1; // keep words in order.
				end
				due_q.push_back(due);
				data_q.push_back(mem.exists(i_cmd.addr) ? mem[i_cmd.addr] : fill_word(i_cmd.addr));
			end
			ready_q <= o_init_done && ($urandom_range(2, 0) == 0); // random accept delay.
			if ((due_q.size() > 0) && (due_q[0] <= cycle)) begin
				o_rdata_valid <= 1'b1;
				o_rdata <= data_q.pop_front();
				void'(due_q.pop_front());
			end else begin
				o_rdata_valid <= 1'b0;
			end
		end
	end

endmodule

// ==== sdram_bridge_top.sv ====
// SDRAM request bridge
`timescale 1ns/10ps
`include "sdram_config.svh"

module sdram_bridge_top
	import sdram_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	// processor port
	input logic i_request,
	input mem_req_t i_req,
	output logic [`SDRAM_DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_error,

	// register port
	input logic i_csr_write,
	input csr_index_e i_csr_index,
	input logic [`SDRAM_DATA_W-1:0] i_csr_wdata,
	output logic [`SDRAM_DATA_W-1:0] o_csr_rdata,

	// controller local port
	output avl_cmd_t o_avl_cmd,
	input logic i_avl_ready,
	input logic i_avl_rdata_valid,
	input logic [`SDRAM_DATA_W-1:0] i_avl_rdata,
	input logic i_init_done
);

	logic enable;
	logic [15:0] timeout_limit;
	bridge_event_t bridge_event;

	sdram_request_fsm fsm_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_req(i_req),
		.i_enable(enable),
		.i_timeout_limit(timeout_limit),
		.i_init_done(i_init_done),
		.i_avl_ready(i_avl_ready),
		.i_avl_rdata_valid(i_avl_rdata_valid),
		.i_avl_rdata(i_avl_rdata),
		.o_avl_cmd(o_avl_cmd),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_error(o_error),
		.o_event(bridge_event)
	);

	sdram_csr csr_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_csr_write(i_csr_write),
		.i_csr_index(i_csr_index),
		.i_csr_wdata(i_csr_wdata),
		.o_csr_rdata(o_csr_rdata),
		.i_event(bridge_event),
		.o_enable(enable),
		.o_timeout_limit(timeout_limit)
	);

endmodule

// ==== sdram_csr.sv ====
// SDRAM bridge control and status
`timescale 1ns/10ps
`include "sdram_config.svh"

module sdram_csr
	import sdram_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	input logic i_csr_write,
	input csr_index_e i_csr_index,
	input logic [`SDRAM_DATA_W-1:0] i_csr_wdata,
	output logic [`SDRAM_DATA_W-1:0] o_csr_rdata,

	input bridge_event_t i_event,

	output logic o_enable,
	output logic [15:0] o_timeout_limit
);

	localparam int NUM_COUNTERS = 3;

	logic enable_q;
	logic [15:0] limit_q;
	logic [NUM_COUNTERS-1:0][`SDRAM_COUNT_W-1:0] count_q;
	logic [NUM_COUNTERS-1:0] event_vec;
	logic [NUM_COUNTERS-1:0] clear_vec;

	// counter order follows the register index.
	assign event_vec = {i_event.timeout, i_event.write_done, i_event.read_done};

	always_comb begin
		for (int i = 0; i < NUM_COUNTERS; i++) begin
			clear_vec[i] = i_csr_write && (i_csr_index == csr_index_e'(CSR_READS + i));
		end
	end

	// ------------------------------
	// control registers
	// ------------------------------

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			enable_q <= 1'b1;
			limit_q <= 16'(`SDRAM_TIMEOUT_DEFAULT);
		end else if (i_csr_write) begin
			if (i_csr_index == CSR_CTRL) begin
				enable_q <= i_csr_wdata[0];
			end
			if (i_csr_index == CSR_TIMEOUT) begin
				limit_q <= i_csr_wdata[15:0];
			end
		end
	end

	// ------------------------------
	// event counters
	// ------------------------------

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count_q <= '0;
		end else begin
			for (int i = 0; i < NUM_COUNTERS; i++) begin
				if (clear_vec[i]) begin
					count_q[i] <= '0; // clear wins over event.
				end else if (event_vec[i] && (count_q[i] != '1)) begin
					count_q[i] <= count_q[i] + 1'b1;
				end
			end
		end
	end

	// read back.
	always_comb begin
		o_csr_rdata = '0;
		case (i_csr_index)
			CSR_CTRL: o_csr_rdata[0] = enable_q;
			CSR_TIMEOUT: o_csr_rdata[15:0] = limit_q;
			CSR_READS: o_csr_rdata[`SDRAM_COUNT_W-1:0] = count_q[0];
			CSR_WRITES: o_csr_rdata[`SDRAM_COUNT_W-1:0] = count_q[1];
			CSR_TIMEOUTS: o_csr_rdata[`SDRAM_COUNT_W-1:0] = count_q[2];
			default: o_csr_rdata = '0;
		endcase
	end

	assign o_enable = enable_q;
	assign o_timeout_limit = limit_q;

endmodule

// ==== sdram_request_fsm.sv ====
// SDRAM request state machine
`timescale 1ns/10ps
`include "sdram_config.svh"

module sdram_request_fsm
	import sdram_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	input logic i_request,
	input mem_req_t i_req,

	input logic i_enable,
	input logic [15:0] i_timeout_limit,

	input logic i_init_done,
	input logic i_avl_ready,
	input logic i_avl_rdata_valid,
	input logic [`SDRAM_DATA_W-1:0] i_avl_rdata,
	output avl_cmd_t o_avl_cmd,

	output logic [`SDRAM_DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_error,
	output bridge_event_t o_event
);

	bridge_state_e state_q;
	bridge_state_e state_d;

	logic [15:0] timer_q;
	logic [3:0] owed_q; // late read words still to come.
	logic read_done_q;

	logic issuing;
	logic expired;
	logic write_ack;
	logic error;
	logic capture;
	logic late_word;
	logic wait_abort;

	assign expired = (timer_q >= i_timeout_limit);
	assign late_word = i_avl_rdata_valid && (owed_q != '0);
	assign wait_abort = error && (state_q == WAIT_DATA);

	// ------------------------------
	// next state
	// ------------------------------

	always_comb begin
		state_d = state_q;
		issuing = 1'b0;
		write_ack = 1'b0;
		error = 1'b0;
		capture = 1'b0;

		case (state_q)
			IDLE: begin
				if (i_request && i_enable && i_init_done) begin
					issuing = 1'b1; // command goes out this cycle.
					state_d = ISSUE;
				end
			end
			ISSUE: begin
				issuing = 1'b1;
			end
			WAIT_DATA: begin
				if (i_avl_rdata_valid && (owed_q == '0)) begin
					capture = 1'b1;
					state_d = HOLD;
				end else if (expired) begin
					error = 1'b1;
					state_d = HOLD;
				end
			end
			HOLD: begin
				if (!i_request) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase

		// the first issue cycle may already be the acceptance
		if (issuing) begin
			if (i_avl_ready) begin
				if (i_req.rw) begin
					write_ack = 1'b1;
					state_d = HOLD;
				end else begin
					state_d = WAIT_DATA;
				end
			end else if ((state_q == ISSUE) && expired) begin
				error = 1'b1;
				state_d = HOLD;
			end
		end
	end

	// ------------------------------
	// command and responses
	// ------------------------------

	always_comb begin
		o_avl_cmd.read_req = issuing && !i_req.rw;
		o_avl_cmd.write_req = issuing && i_req.rw;
		o_avl_cmd.burstbegin = issuing;
		o_avl_cmd.addr = i_req.addr[`SDRAM_AVL_ADDR_W+1:2];
		o_avl_cmd.wdata = i_req.wdata;
	end

	assign o_ready = write_ack || read_done_q;
	assign o_error = error;

	assign o_event.read_done = read_done_q;
	assign o_event.write_done = write_ack;
	assign o_event.timeout = error;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state_q <= IDLE;
			timer_q <= '0;
			owed_q <= '0;
			read_done_q <= 1'b0;
		end else begin
			state_q <= state_d;
			read_done_q <= capture;

			if ((state_q == ISSUE) || (state_q == WAIT_DATA)) begin
				if (!expired) begin
					timer_q <= timer_q + 16'd1;
				end
			end else begin
				timer_q <= '0;
			end

			// an abandoned read still owes one word.
			if (wait_abort && !late_word && (owed_q != '1)) begin
				owed_q <= owed_q + 4'd1;
			end else if (late_word && !wait_abort) begin
				owed_q <= owed_q - 4'd1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (capture) begin
			o_rdata <= i_avl_rdata; // held until next read.
		end
	end

endmodule

// ==== sdram_pkg.sv ====
// SDRAM bridge types
`include "sdram_config.svh"

package sdram_pkg;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE, // held until accepted.
		WAIT_DATA, // read accepted, data pending.
		HOLD // done, waiting for request low.
	} bridge_state_e;

	typedef enum logic [2:0] {
		CSR_CTRL = 3'd0, // bit 0 enable.
		CSR_TIMEOUT = 3'd1,
		CSR_READS = 3'd2,
		CSR_WRITES = 3'd3,
		CSR_TIMEOUTS = 3'd4
	} csr_index_e;

	typedef struct packed {
		logic rw; // 1 is write.
		logic [`SDRAM_ADDR_W-1:0] addr;
		logic [`SDRAM_DATA_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic read_req;
		logic write_req;
		logic burstbegin;
		logic [`SDRAM_AVL_ADDR_W-1:0] addr;
		logic [`SDRAM_DATA_W-1:0] wdata;
	} avl_cmd_t;

	typedef struct packed {
		logic read_done;
		logic write_done;
		logic timeout;
	} bridge_event_t;

endpackage

// ==== sdram_config.svh ====
// SDRAM bridge configuration
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// ------------------------------
// data path
// ------------------------------

`define SDRAM_DATA_W 32 // word width.

// processor side is byte addressed, controller side is word addressed
`define SDRAM_ADDR_W 32
`define SDRAM_AVL_ADDR_W 27 // byte address bits 28 down to 2.

// ------------------------------
// control and status
// ------------------------------

`define SDRAM_TIMEOUT_DEFAULT 64 // cycles after reset.
`define SDRAM_COUNT_W 16

`endif
